//--- verilog/matadd_pkg.sv
// shared types, register bus struct and matrix constants for the matrix adder
`default_nettype none

package matadd_pkg;

    // one IEEE-754 double
    typedef logic [63:0] fp64_t;

    // register bus
    typedef logic [1:0]  csr_addr_t;
    typedef logic [31:0] csr_data_t;

    typedef struct packed {
        logic      we;
        csr_addr_t addr;
        csr_data_t wdata;
    } csr_req_t;

    // elements in one 4x4 matrix
    localparam int mat_elems = 16;

    // register map
    // bit 0 of ctrl selects subtract
    localparam csr_addr_t csr_ctrl  = 2'd0;
    localparam csr_addr_t csr_beats = 2'd1;
    localparam csr_addr_t csr_mats  = 2'd2;

    // canonical quiet NaN
    localparam fp64_t fp64_qnan = 64'h7FF8_0000_0000_0000;

endpackage

`default_nettype wire

//--- verilog/fp64_adder.sv
// multi-cycle double-precision adder with strobe/acknowledge handshake
`default_nettype none
`timescale 1ns/10ps

module fp64_adder (
    input  wire                clk,
    input  wire                rst,
    input  wire matadd_pkg::fp64_t a,
    input  wire matadd_pkg::fp64_t b,
    input  wire                a_stb,
    output logic               a_ack,
    output matadd_pkg::fp64_t  z,
    output logic               z_stb,
    input  wire                z_ack
);

    import matadd_pkg::*;

    typedef enum logic [2:0] {
        st_idle,
        st_unpack,
        st_special,
        st_align,
        st_add,
        st_normalize,
        st_round,
        st_hold
    } adder_state_t;

    // biased exponent with headroom for over/underflow
    typedef logic signed [12:0] exp_t;
    // hidden bit, 52 fraction bits, guard, round, sticky
    typedef logic [55:0] mant_t;

    adder_state_t state;

    fp64_t       a_r;
    fp64_t       b_r;
    fp64_t       z_r;
    logic        a_s;
    logic        b_s;
    logic        z_s;
    exp_t        a_e;
    exp_t        b_e;
    exp_t        z_e;
    mant_t       a_m;
    mant_t       b_m;
    logic [56:0] sum_m;

    logic        a_nan;
    logic        b_nan;
    logic        a_inf;
    logic        b_inf;
    logic        a_zero;
    logic        b_zero;

    exp_t        e_diff;
    logic        round_up;
    logic [53:0] mant_rnd;
    logic [51:0] frac_rnd;
    exp_t        e_rnd;

    // special-value decode from the captured operands
    assign a_nan  = (a_r[62:52] == 11'h7FF) && (a_r[51:0] != '0);
    assign b_nan  = (b_r[62:52] == 11'h7FF) && (b_r[51:0] != '0);
    assign a_inf  = (a_r[62:52] == 11'h7FF) && (a_r[51:0] == '0);
    assign b_inf  = (b_r[62:52] == 11'h7FF) && (b_r[51:0] == '0);
    // denormals are flushed, so a zero exponent means zero
    assign a_zero = (a_r[62:52] == 11'd0);
    assign b_zero = (b_r[62:52] == 11'd0);

    assign e_diff = a_e - b_e;

    // round to nearest, ties to even
    always_comb begin
        round_up = sum_m[2] & (sum_m[1] | sum_m[0] | sum_m[3]);
        mant_rnd = {1'b0, sum_m[55:3]} + 54'(round_up);
        e_rnd    = z_e;
        frac_rnd = mant_rnd[51:0];
        if (mant_rnd[53]) begin
            // a carry out of rounding makes the mantissa 1.0
            e_rnd    = z_e + 13'sd1;
            frac_rnd = mant_rnd[52:1];
        end
    end

    assign a_ack = (state == st_idle);
    assign z_stb = (state == st_hold);
    assign z     = z_r;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle: begin
                    if (a_stb) begin
                        a_r   <= a;
                        b_r   <= b;
                        state <= st_unpack;
                    end
                end
                st_unpack: begin
                    a_s   <= a_r[63];
                    b_s   <= b_r[63];
                    a_e   <= exp_t'({2'b00, a_r[62:52]});
                    b_e   <= exp_t'({2'b00, b_r[62:52]});
                    a_m   <= {a_r[62:52] != 11'd0, a_r[51:0], 3'b000};
                    b_m   <= {b_r[62:52] != 11'd0, b_r[51:0], 3'b000};
                    state <= st_special;
                end
                st_special: begin
                    state <= st_hold;
                    if (a_nan || b_nan) begin
                        z_r <= fp64_qnan;
                    end else if (a_inf) begin
                        z_r <= (b_inf && (a_s != b_s)) ? fp64_qnan : a_r;
                    end else if (b_inf) begin
                        z_r <= b_r;
                    end else if (a_zero && b_zero) begin
                        // only -0 plus -0 keeps the sign
                        z_r <= {a_s & b_s, 63'd0};
                    end else if (a_zero) begin
                        z_r <= b_r;
                    end else if (b_zero) begin
                        z_r <= a_r;
                    end else begin
                        state <= st_align;
                    end
                end
                st_align: begin
                    // shift the smaller operand one bit per cycle
                    if (e_diff > 0) begin
                        if (e_diff > 13'sd56) begin
                            b_m <= {55'd0, |b_m};
                            b_e <= a_e;
                        end else begin
                            b_m <= {1'b0, b_m[55:2], |b_m[1:0]};
                            b_e <= b_e + 13'sd1;
                        end
                    end else if (e_diff < 0) begin
                        if (e_diff < -13'sd56) begin
                            a_m <= {55'd0, |a_m};
                            a_e <= b_e;
                        end else begin
                            a_m <= {1'b0, a_m[55:2], |a_m[1:0]};
                            a_e <= a_e + 13'sd1;
                        end
                    end else begin
                        state <= st_add;
                    end
                end
                st_add: begin
                    z_e   <= a_e;
                    state <= st_normalize;
                    if (a_s == b_s) begin
                        sum_m <= {1'b0, a_m} + {1'b0, b_m};
                        z_s   <= a_s;
                    end else if (a_m == b_m) begin
                        // exact cancellation gives +0
                        z_r   <= '0;
                        state <= st_hold;
                    end else if (a_m > b_m) begin
                        sum_m <= {1'b0, a_m} - {1'b0, b_m};
                        z_s   <= a_s;
                    end else begin
                        sum_m <= {1'b0, b_m} - {1'b0, a_m};
                        z_s   <= b_s;
                    end
                end
                st_normalize: begin
                    if (sum_m[56]) begin
                        sum_m <= {1'b0, sum_m[56:2], |sum_m[1:0]};
                        z_e   <= z_e + 13'sd1;
                    end else if (!sum_m[55]) begin
                        sum_m <= {sum_m[55:0], 1'b0};
                        z_e   <= z_e - 13'sd1;
                    end else begin
                        state <= st_round;
                    end
                end
                st_round: begin
                    if (e_rnd >= 13'sd2047) begin
                        z_r <= {z_s, 11'h7FF, 52'd0};
                    end else if (e_rnd <= 0) begin
                        // underflow flushes to zero
                        z_r <= {z_s, 63'd0};
                    end else begin
                        z_r <= {z_s, e_rnd[10:0], frac_rnd};
                    end
                    state <= st_hold;
                end
                st_hold: begin
                    if (z_ack) begin
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // result stays put until the controller takes it
    assert property (@(posedge clk) disable iff (rst)
        z_stb && !z_ack |=> z_stb && $stable(z));

endmodule

`default_nettype wire

//--- verilog/mat_csr.sv
// control and status registers: subtract mode, beat and matrix counters
`default_nettype none
`timescale 1ns/10ps

module mat_csr (
    input  wire                     clk,
    input  wire                     rst,
    input  wire matadd_pkg::csr_req_t csr_req,
    input  wire                     csr_req_valid,
    output matadd_pkg::csr_data_t   csr_rdata,
    input  wire                     beat_done,
    input  wire                     mat_done,
    output logic                    sub_mode
);

    import matadd_pkg::*;

    csr_data_t beat_cnt;
    csr_data_t mat_cnt;
    logic      wr_en;

    assign wr_en = csr_req_valid && csr_req.we;

    always_ff @(posedge clk) begin
        if (rst) begin
            sub_mode <= 1'b0;
            beat_cnt <= '0;
            mat_cnt  <= '0;
        end else begin
            // counters wrap
            if (beat_done) begin
                beat_cnt <= beat_cnt + 1'b1;
            end
            if (mat_done) begin
                mat_cnt <= mat_cnt + 1'b1;
            end
            // a write wins over a same-cycle increment
            if (wr_en) begin
                case (csr_req.addr)
                    csr_ctrl:  sub_mode <= csr_req.wdata[0];
                    csr_beats: beat_cnt <= '0;
                    csr_mats:  mat_cnt  <= '0;
                    default: ;
                endcase
            end
        end
    end

    always_comb begin
        case (csr_req.addr)
            csr_ctrl:  csr_rdata = {31'd0, sub_mode};
            csr_beats: csr_rdata = beat_cnt;
            csr_mats:  csr_rdata = mat_cnt;
            default:   csr_rdata = '0;
        endcase
    end

    // address 3 is not mapped
    assert property (@(posedge clk) disable iff (rst)
        wr_en |-> csr_req.addr != csr_addr_t'(3));

endmodule

`default_nettype wire

//--- verilog/mat_lane_ctrl.sv
// lane controller: operand beats to adder lanes, result beats with last flag
`default_nettype none
`timescale 1ns/10ps

module mat_lane_ctrl #(
    parameter int LANES = 4
) (
    input  wire                    clk,
    input  wire                    rst,
    input  wire                    in_valid,
    output logic                   in_ready,
    input  wire  [LANES*64-1:0]    in_a,
    input  wire  [LANES*64-1:0]    in_b,
    output logic                   out_valid,
    input  wire                    out_ready,
    output logic [LANES*64-1:0]    out_c,
    output logic                   out_last,
    input  wire                    sub_mode,
    output logic                   beat_done,
    output logic                   mat_done,
    output logic [LANES-1:0]       lane_a_stb,
    input  wire  [LANES-1:0]       lane_a_ack,
    output logic [LANES*64-1:0]    lane_a,
    output logic [LANES*64-1:0]    lane_b,
    input  wire  [LANES*64-1:0]    lane_z,
    input  wire  [LANES-1:0]       lane_z_stb,
    output logic [LANES-1:0]       lane_z_ack
);

    import matadd_pkg::*;

    localparam int BEATS = mat_elems / LANES;
    localparam int IW    = (BEATS > 1) ? $clog2(BEATS) : 1;
    localparam logic [IW-1:0] last_idx = IW'(BEATS - 1);
    localparam fp64_t sign_mask = {1'b1, 63'd0};

    typedef enum logic [1:0] {
        st_idle,
        st_compute,
        st_deliver
    } ctrl_state_t;

    ctrl_state_t   state;
    logic [IW-1:0] beat_idx;
    logic          all_done;

    // results are taken only once every lane has finished
    assign all_done   = &lane_z_stb;
    assign in_ready   = (state == st_idle);
    assign lane_z_ack = {LANES{(state == st_compute) && all_done}};
    assign beat_done  = out_valid && out_ready;
    assign mat_done   = beat_done && out_last;

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= st_idle;
            lane_a_stb <= '0;
            out_valid  <= 1'b0;
            out_last   <= 1'b0;
            beat_idx   <= '0;
        end else begin
            case (state)
                st_idle: begin
                    if (in_valid) begin
                        // mode is sampled here and subtract flips the sign of b
                        for (int k = 0; k < LANES; k++) begin
                            lane_a[k*64 +: 64] <= in_a[k*64 +: 64];
                            lane_b[k*64 +: 64] <= in_b[k*64 +: 64]
                                                  ^ (sub_mode ? sign_mask : '0);
                        end
                        lane_a_stb <= '1;
                        state      <= st_compute;
                    end
                end
                st_compute: begin
                    lane_a_stb <= lane_a_stb & ~lane_a_ack;
                    if (all_done) begin
                        out_c     <= lane_z;
                        out_valid <= 1'b1;
                        out_last  <= (beat_idx == last_idx);
                        state     <= st_deliver;
                    end
                end
                st_deliver: begin
                    if (out_ready) begin
                        out_valid <= 1'b0;
                        beat_idx  <= (beat_idx == last_idx) ? '0 : beat_idx + 1'b1;
                        state     <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // result beat is held under back-pressure
    assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> out_valid && $stable(out_c) && $stable(out_last));

endmodule

`default_nettype wire

//--- verilog/mat_add_top.sv
// matrix adder top: register block, lane controller and adder lanes
`default_nettype none
`timescale 1ns/10ps

module mat_add_top #(
    parameter int LANES = 4
) (
    input  wire                       clk,
    input  wire                       rst,
    input  wire                       in_valid,
    output logic                      in_ready,
    input  wire  [LANES*64-1:0]       in_a,
    input  wire  [LANES*64-1:0]       in_b,
    output logic                      out_valid,
    input  wire                       out_ready,
    output logic [LANES*64-1:0]       out_c,
    output logic                      out_last,
    input  wire matadd_pkg::csr_req_t csr_req,
    input  wire                       csr_req_valid,
    output matadd_pkg::csr_data_t     csr_rdata
);

    logic                sub_mode;
    logic                beat_done;
    logic                mat_done;
    logic [LANES-1:0]    lane_a_stb;
    logic [LANES-1:0]    lane_a_ack;
    logic [LANES*64-1:0] lane_a;
    logic [LANES*64-1:0] lane_b;
    logic [LANES*64-1:0] lane_z;
    logic [LANES-1:0]    lane_z_stb;
    logic [LANES-1:0]    lane_z_ack;

    mat_csr u_csr (
        .clk           (clk),
        .rst           (rst),
        .csr_req       (csr_req),
        .csr_req_valid (csr_req_valid),
        .csr_rdata     (csr_rdata),
        .beat_done     (beat_done),
        .mat_done      (mat_done),
        .sub_mode      (sub_mode)
    );

    mat_lane_ctrl #(
        .LANES (LANES)
    ) u_ctrl (
        .clk        (clk),
        .rst        (rst),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .in_a       (in_a),
        .in_b       (in_b),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_c      (out_c),
        .out_last   (out_last),
        .sub_mode   (sub_mode),
        .beat_done  (beat_done),
        .mat_done   (mat_done),
        .lane_a_stb (lane_a_stb),
        .lane_a_ack (lane_a_ack),
        .lane_a     (lane_a),
        .lane_b     (lane_b),
        .lane_z     (lane_z),
        .lane_z_stb (lane_z_stb),
        .lane_z_ack (lane_z_ack)
    );

    // one adder per lane
    for (genvar k = 0; k < LANES; k++) begin : g_lane
        fp64_adder u_add (
            .clk   (clk),
            .rst   (rst),
            .a     (lane_a[k*64 +: 64]),
            .b     (lane_b[k*64 +: 64]),
            .a_stb (lane_a_stb[k]),
            .a_ack (lane_a_ack[k]),
            .z     (lane_z[k*64 +: 64]),
            .z_stb (lane_z_stb[k]),
            .z_ack (lane_z_ack[k])
        );
    end

endmodule

`default_nettype wire

//--- tests/mat_add_tests.svh
// directed test tasks for the matrix adder, included in the testbench module

localparam logic [63:0] pos_inf  = 64'h7FF0_0000_0000_0000;
localparam logic [63:0] neg_inf  = 64'hFFF0_0000_0000_0000;
localparam logic [63:0] one_bits = 64'h3FF0_0000_0000_0000;

logic [63:0] mat_a [16];
logic [63:0] mat_b [16];
logic [63:0] mat_c [16];

// normal double with exponent within 20 of the bias
function automatic logic [63:0] rand_double();
    logic [63:0] bits;
    logic [10:0] expo;
    bits = {$random(seed), $random(seed)};
    expo = 11'(1003 + ({$random(seed)} % 41));
    return {bits[63], expo, bits[51:0]};
endfunction

// expected element from real arithmetic with every NaN made quiet
function automatic logic [63:0] ref_sum(input logic [63:0] a, input logic [63:0] b,
                                        input logic sub);
    logic [63:0] b_eff;
    logic [63:0] r;
    b_eff = sub ? {~b[63], b[62:0]} : b;
    r     = $realtobits($bitstoreal(a) + $bitstoreal(b_eff));
    if (r[62:52] == 11'h7FF && r[51:0] != 52'd0) begin
        r = qnan_bits;
    end
    return r;
endfunction

task automatic fill_random(input logic sub);
    for (int i = 0; i < 16; i++) begin
        mat_a[i] = rand_double();
        mat_b[i] = rand_double();
        mat_c[i] = ref_sum(mat_a[i], mat_b[i], sub);
    end
endtask

task automatic set_case(input int idx, input logic [63:0] a, input logic [63:0] b,
                        input logic [63:0] c);
    mat_a[idx] = a;
    mat_b[idx] = b;
    mat_c[idx] = c;
endtask

task automatic stream_matrix(input int max_stall);
    logic [lanes*64-1:0] va;
    logic [lanes*64-1:0] vb;
    logic [lanes*64-1:0] vc;
    int                  stall;
    for (int beat = 0; beat < beats_per_mat; beat++) begin
        for (int k = 0; k < lanes; k++) begin
            va[k*64 +: 64] = mat_a[beat*lanes + k];
            vb[k*64 +: 64] = mat_b[beat*lanes + k];
            vc[k*64 +: 64] = mat_c[beat*lanes + k];
        end
        stall = (max_stall > 0) ? 1 + int'({$random(seed)} % max_stall) : 0;
        send_beat(va, vb);
        recv_beat(vc, beat == beats_per_mat - 1, stall);
    end
endtask

task automatic check_reset_state();
    check_val("in_ready", in_ready, 1'b1);
    check_val("out_valid", out_valid, 1'b0);
    csr_check(csr_ctrl, 32'd0, "csr_rdata[ctrl]");
    csr_check(csr_beats, 32'd0, "csr_rdata[beats]");
    csr_check(csr_mats, 32'd0, "csr_rdata[mats]");
endtask

task automatic add_two_matrices();
    repeat (2) begin
        fill_random(1'b0);
        stream_matrix(0);
    end
endtask

task automatic subtract_then_add();
    csr_write(csr_ctrl, 32'd1);
    csr_check(csr_ctrl, 32'd1, "csr_rdata[ctrl]");
    fill_random(1'b1);
    stream_matrix(0);
    // back to add for the next matrix
    csr_write(csr_ctrl, 32'd0);
    fill_random(1'b0);
    stream_matrix(0);
endtask

task automatic special_values();
    fill_random(1'b0);
    set_case(0, pos_inf, neg_inf, qnan_bits);
    set_case(1, neg_inf, pos_inf, qnan_bits);
    set_case(2, pos_inf, one_bits, pos_inf);
    set_case(3, 64'hC004_0000_0000_0000, neg_inf, neg_inf);
    set_case(4, 64'h400E_0000_0000_0000, 64'hC00E_0000_0000_0000, 64'd0);
    set_case(5, 64'd0, 64'h8000_0000_0000_0000, 64'd0);
    set_case(6, 64'h8000_0000_0000_0000, 64'd0, 64'd0);
    set_case(7, 64'h7FF0_0000_0000_0001, one_bits, qnan_bits);
    set_case(8, one_bits, 64'hFFF8_0000_0000_0000, qnan_bits);
    set_case(9, pos_inf, pos_inf, pos_inf);
    set_case(10, one_bits, 64'd0, one_bits);
    stream_matrix(0);
endtask

task automatic back_pressure_run();
    repeat (2) begin
        fill_random(1'b0);
        stream_matrix(12);
    end
endtask

task automatic counter_readback();
    csr_check(csr_beats, csr_data_t'(beats_seen), "csr_rdata[beats]");
    csr_check(csr_mats, csr_data_t'(mats_seen), "csr_rdata[mats]");
    // any write clears a counter
    csr_write(csr_beats, 32'h0000_FFFF);
    csr_check(csr_beats, 32'd0, "csr_rdata[beats]");
    csr_write(csr_mats, 32'd1);
    csr_check(csr_mats, 32'd0, "csr_rdata[mats]");
endtask

//--- tests/tb_mat_add.sv
// testbench top for the matrix adder: clock, reset, DUT, watchdog and check helpers
`default_nettype none
`timescale 1ns/10ps

module tb_mat_add;

    import matadd_pkg::*;

    localparam int lanes         = 4;
    localparam int beats_per_mat = 16 / lanes;
    localparam int clk_half_ns   = 10;
    // 40 beats at up to 100 cycles each
    localparam int watchdog_cycles = 40 * 100;
    localparam logic [63:0] qnan_bits = 64'h7FF8_0000_0000_0000;

    logic                  clk;
    logic                  rst;
    logic                  in_valid;
    logic                  in_ready;
    logic [lanes*64-1:0]   in_a;
    logic [lanes*64-1:0]   in_b;
    logic                  out_valid;
    logic                  out_ready;
    logic [lanes*64-1:0]   out_c;
    logic                  out_last;
    csr_req_t              csr_req;
    logic                  csr_req_valid;
    csr_data_t             csr_rdata;

    integer seed;
    int     beats_seen;
    int     mats_seen;

    mat_add_top #(
        .LANES (lanes)
    ) DUT (
        .clk           (clk),
        .rst           (rst),
        .in_valid      (in_valid),
        .in_ready      (in_ready),
        .in_a          (in_a),
        .in_b          (in_b),
        .out_valid     (out_valid),
        .out_ready     (out_ready),
        .out_c         (out_c),
        .out_last      (out_last),
        .csr_req       (csr_req),
        .csr_req_valid (csr_req_valid),
        .csr_rdata     (csr_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #clk_half_ns clk = ~clk;
    end

    task automatic abort_run();
        $display("Test FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_val(input string name, input logic [255:0] got,
                             input logic [255:0] exp);
        assert (got === exp) else begin
            $display("** Error: %s expected %0h got %0h", name, exp, got);
            abort_run();
        end
    endtask

    // every driver task starts and ends on a falling edge
    task automatic send_beat(input logic [lanes*64-1:0] a_vec,
                             input logic [lanes*64-1:0] b_vec);
        in_a     = a_vec;
        in_b     = b_vec;
        in_valid = 1'b1;
        while (!in_ready) begin
            @(negedge clk);
        end
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    task automatic recv_beat(input logic [lanes*64-1:0] exp_c, input logic exp_last,
                             input int stall);
        logic [lanes*64-1:0] held_c;
        logic                held_last;
        out_ready = (stall == 0);
        while (!out_valid) begin
            @(negedge clk);
        end
        held_c    = out_c;
        held_last = out_last;
        // under back-pressure the beat must sit still
        repeat (stall) begin
            @(negedge clk);
            check_val("out_valid", out_valid, 1'b1);
            check_val("out_c", out_c, held_c);
            check_val("out_last", out_last, held_last);
            check_val("in_ready", in_ready, 1'b0);
        end
        out_ready = 1'b1;
        for (int k = 0; k < lanes; k++) begin
            check_val($sformatf("out_c[%0d]", k), out_c[k*64 +: 64], exp_c[k*64 +: 64]);
        end
        check_val("out_last", out_last, exp_last);
        @(negedge clk);
        out_ready = 1'b0;
        check_val("out_valid", out_valid, 1'b0);
        beats_seen++;
        if (exp_last) begin
            mats_seen++;
        end
    endtask

    task automatic csr_write(input csr_addr_t addr, input csr_data_t data);
        csr_req.we    = 1'b1;
        csr_req.addr  = addr;
        csr_req.wdata = data;
        csr_req_valid = 1'b1;
        @(negedge clk);
        csr_req_valid = 1'b0;
        csr_req.we    = 1'b0;
    endtask

    task automatic csr_check(input csr_addr_t addr, input csr_data_t exp, input string name);
        csr_req.addr = addr;
        #1;
        check_val(name, csr_rdata, exp);
        @(negedge clk);
    endtask

    // watchdog
    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        $display("timeout: tests did not finish within %0d cycles", watchdog_cycles);
        abort_run();
    end

    initial begin
        seed          = 32'h3022;
        beats_seen    = 0;
        mats_seen     = 0;
        in_valid      = 1'b0;
        in_a          = '0;
        in_b          = '0;
        out_ready     = 1'b0;
        csr_req       = '0;
        csr_req_valid = 1'b0;
        rst           = 1'b1;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        check_reset_state();
        add_two_matrices();
        subtract_then_add();
        special_values();
        back_pressure_run();
        counter_readback();
        $display("Test OK");
        $finish;
    end

    `include "mat_add_tests.svh"

endmodule

`default_nettype wire

//--- flist.f
+incdir+tests
verilog/matadd_pkg.sv
verilog/fp64_adder.sv
verilog/mat_csr.sv
verilog/mat_lane_ctrl.sv
verilog/mat_add_top.sv
tests/tb_mat_add.sv

//--- run.sh
#!/bin/sh
# build and run the matrix adder testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert --timescale 1ns/10ps \
    -f flist.f --top-module tb_mat_add -o sim_mat_add
./obj_dir/sim_mat_add | tee sim.log

if grep -qx "Test OK" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
